// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_branch.sv
rv_fetch_ctrl.sv
rv_core.sv
rv_checker.sv
tb_rv_core.sv

// ==== rv_alu.sv ====
/* Operand selection and integer ALU, producing the write-back value
   of the instruction in execute. */
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::word_t   imm,
    input  rv_pkg::src_a_t  src_a,
    input  rv_pkg::src_b_t  src_b,
    input  rv_pkg::alu_op_t alu_op,
    output rv_pkg::word_t   alu_result
);
    import rv_pkg::*;

    word_t      a;
    word_t      b;
    logic [4:0] shamt;

    always_comb begin
        unique case (src_a)
            SRC_A_PC:   a = pc;
            SRC_A_ZERO: a = '0;   // LUI
            default:    a = rs1_data;
        endcase
        unique case (src_b)
            SRC_B_IMM:  b = imm;
            SRC_B_FOUR: b = 32'd4;  // Link address
            default:    b = rs2_data;
        endcase
    end

    assign shamt = b[4:0];

    always_comb begin
        unique case (alu_op)
            ALU_SUB:  alu_result = a - b;
            ALU_SLL:  alu_result = a << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  alu_result = a ^ b;
            ALU_SRL:  alu_result = a >> shamt;
            ALU_SRA:  alu_result = $signed(a) >>> shamt;
            ALU_OR:   alu_result = a | b;
            ALU_AND:  alu_result = a & b;
            default:  alu_result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_branch.sv ====
/* Branch condition evaluation and jump target for conditional branches,
   JAL and JALR. */
`timescale 1ns/10ps
`default_nettype none

module rv_branch (
    input  rv_pkg::word_t        pc,
    input  rv_pkg::word_t        rs1_data,
    input  rv_pkg::word_t        rs2_data,
    input  rv_pkg::word_t        imm,
    input  rv_pkg::branch_kind_t branch_kind,
    input  logic [2:0]           br_cond,
    output logic                 jump_en,
    output rv_pkg::word_t        jump_target
);
    import rv_pkg::*;

    word_t base;
    word_t sum;
    logic  taken;

    assign base = (branch_kind == BR_JALR) ? rs1_data : pc;
    assign sum  = base + imm;
    // PC-relative targets are already even, so clearing bit 0 only matters for JALR
    assign jump_target = {sum[XLEN-1:1], 1'b0};

    always_comb begin
        unique case (br_cond)
            3'b000:  taken = rs1_data == rs2_data;                    // BEQ
            3'b001:  taken = rs1_data != rs2_data;                    // BNE
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);   // BLT
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);  // BGE
            3'b110:  taken = rs1_data < rs2_data;                     // BLTU
            3'b111:  taken = rs1_data >= rs2_data;                    // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        unique case (branch_kind)
            BR_COND:         jump_en = taken;
            BR_JAL, BR_JALR: jump_en = 1'b1;
            default:         jump_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_checker.sv ====
/* Commit and bus monitor for the core testbench. Compares each commit with the
   expected table and checks the Wishbone and fetch-error behavior. */
`timescale 1ns/10ps
`default_nettype none

module rv_checker #(
    parameter int NUM_COMMITS = 24
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  rv_pkg::word_t    wb_adr,
    input  logic             wb_ack,
    input  logic             wb_err,
    input  logic             commit_valid,
    input  rv_pkg::word_t    commit_pc,
    input  rv_pkg::reg_idx_t commit_rd,
    input  logic             commit_we,
    input  rv_pkg::word_t    commit_wdata,
    input  logic             fetch_error,
    input  logic             end_of_test,
    input  rv_pkg::word_t    exp_pc [NUM_COMMITS],
    input  rv_pkg::reg_idx_t exp_rd [NUM_COMMITS],
    input  logic             exp_we [NUM_COMMITS],
    input  rv_pkg::word_t    exp_wdata [NUM_COMMITS],
    output int               commits,
    output int               errors
);
    import rv_pkg::*;

    logic  fetch_started;
    logic  acked;      // At least one fetch finished
    logic  err_seen;
    logic  end_checked;
    logic  stall_q;
    logic  answered_q; // Slave answered in the previous cycle
    word_t adr_q;

    task automatic report_mismatch(input string what, input word_t got, input word_t want);
        $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        errors++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            commits       = 0;
            errors        = 0;
            fetch_started = 1'b0;
            acked         = 1'b0;
            err_seen      = 1'b0;
            end_checked   = 1'b0;
            stall_q       = 1'b0;
            answered_q    = 1'b0;
            adr_q         = '0;
            if (wb_cyc || wb_stb || commit_valid || fetch_error)
                report_problem("bus, commit or error output active during reset");
        end else begin
            if (wb_cyc && !fetch_started) begin
                fetch_started = 1'b1;
                if (wb_adr !== RESET_PC)
                    report_mismatch("first fetch address", wb_adr, RESET_PC);
            end
            if (wb_stb !== wb_cyc)
                report_problem("wb_stb and wb_cyc were not raised and dropped together");
            // Address must hold through wait states
            if (stall_q && (!wb_cyc || wb_adr !== adr_q))
                report_problem("the fetch request changed before the slave answered");
            if (answered_q && wb_cyc)
                report_problem("the bus cycle stayed open after the slave answered");
            if (commit_valid) begin
                if (!acked) begin
                    report_problem("commit seen before the first fetch was acknowledged");
                end else if (err_seen) begin
                    report_problem("commit seen after the bus error");
                end else if (commits >= NUM_COMMITS) begin
                    report_problem("more commits than the expected table holds");
                end else begin
                    if (commit_pc !== exp_pc[commits])
                        report_mismatch($sformatf("row %0d commit_pc", commits),
                                        commit_pc, exp_pc[commits]);
                    if (commit_we !== exp_we[commits])
                        report_mismatch($sformatf("row %0d commit_we", commits),
                                        32'(commit_we), 32'(exp_we[commits]));
                    if (exp_we[commits] && commit_rd !== exp_rd[commits])
                        report_mismatch($sformatf("row %0d commit_rd", commits),
                                        32'(commit_rd), 32'(exp_rd[commits]));
                    if (exp_we[commits] && commit_wdata !== exp_wdata[commits])
                        report_mismatch($sformatf("row %0d commit_wdata", commits),
                                        commit_wdata, exp_wdata[commits]);
                    commits++;
                end
            end
            if (err_seen && !fetch_error)
                report_mismatch("fetch_error after bus error", 32'(fetch_error), 32'd1);
            if (err_seen && wb_cyc)
                report_problem("a bus cycle started after the bus error");
            if (!err_seen && fetch_error)
                report_problem("fetch_error rose without a bus error");
            if (wb_cyc && wb_ack)
                acked = 1'b1;
            if (wb_cyc && wb_err)
                err_seen = 1'b1;
            stall_q    = wb_cyc && !wb_ack && !wb_err;
            answered_q = wb_cyc && (wb_ack || wb_err);
            adr_q      = wb_adr;
            if (end_of_test && !end_checked) begin
                end_checked = 1'b1;
                if (commits != NUM_COMMITS)
                    report_mismatch("commit count", 32'(commits), 32'(NUM_COMMITS));
                if (!err_seen)
                    report_problem("no bus error reached the core");
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
/* Top level of the RV32I core: Wishbone fetch port, commit port and
   error flag around the sequencer and the execute units. */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::word_t    wb_dat,
    input  logic             wb_ack,
    input  logic             wb_err,
    output logic             wb_cyc,
    output logic             wb_stb,
    output rv_pkg::word_t    wb_adr,
    output logic             commit_valid,
    output rv_pkg::word_t    commit_pc,
    output rv_pkg::reg_idx_t commit_rd,
    output logic             commit_we,
    output rv_pkg::word_t    commit_wdata,
    output logic             fetch_error
);
    import rv_pkg::*;

    word_t        instr;
    word_t        pc;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    alu_op_t      alu_op;
    src_a_t       src_a;
    src_b_t       src_b;
    logic         rd_write;
    branch_kind_t branch_kind;
    logic [2:0]   br_cond;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        alu_result;
    logic         jump_en;
    word_t        jump_target;
    logic         rf_we;
    reg_idx_t     rf_waddr;
    word_t        rf_wdata;

    rv_fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .reset        (reset),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err),
        .rd_write     (rd_write),
        .rd           (rd),
        .alu_result   (alu_result),
        .jump_en      (jump_en),
        .jump_target  (jump_target),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .instr        (instr),
        .pc           (pc),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_wdata (commit_wdata),
        .fetch_error  (fetch_error)
    );

    rv_decode u_decode (
        .instr       (instr),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .src_a       (src_a),
        .src_b       (src_b),
        .rd_write    (rd_write),
        .branch_kind (branch_kind),
        .br_cond     (br_cond)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ALU and branch unit evaluate side by side in the execute cycle
    rv_alu u_alu (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    rv_branch u_branch (
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .branch_kind (branch_kind),
        .br_cond     (br_cond),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
/* Instruction decoder: register fields, sign-extended immediate and the
   operand, ALU and branch selects for the execute cycle. */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  rv_pkg::word_t        instr,
    output rv_pkg::reg_idx_t     rs1,
    output rv_pkg::reg_idx_t     rs2,
    output rv_pkg::reg_idx_t     rd,
    output rv_pkg::word_t        imm,
    output rv_pkg::alu_op_t      alu_op,
    output rv_pkg::src_a_t       src_a,
    output rv_pkg::src_b_t       src_b,
    output logic                 rd_write,
    output rv_pkg::branch_kind_t branch_kind,
    output logic [2:0]           br_cond
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    arith_op;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rd      = instr[11:7];
    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];
    assign br_cond = funct3;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3/funct7 to operation, shared by OP and OP-IMM
    always_comb begin
        unique case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;  // Same bit for SRAI
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        imm         = '0;
        alu_op      = ALU_ADD;
        src_a       = SRC_A_RS1;
        src_b       = SRC_B_RS2;
        rd_write    = 1'b0;
        branch_kind = BR_NONE;
        unique case (opcode)
            OPC_OP: begin
                alu_op   = arith_op;
                rd_write = 1'b1;
            end
            OPC_OP_IMM: begin
                imm      = imm_i;
                alu_op   = arith_op;
                src_b    = SRC_B_IMM;
                rd_write = 1'b1;
            end
            OPC_LUI: begin
                imm      = imm_u;
                src_a    = SRC_A_ZERO;
                src_b    = SRC_B_IMM;
                rd_write = 1'b1;
            end
            OPC_AUIPC: begin
                imm      = imm_u;
                src_a    = SRC_A_PC;
                src_b    = SRC_B_IMM;
                rd_write = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                imm         = (opcode == OPC_JAL) ? imm_j : imm_i;
                src_a       = SRC_A_PC;     // Link value PC+4
                src_b       = SRC_B_FOUR;
                rd_write    = 1'b1;
                branch_kind = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
            end
            OPC_BRANCH: begin
                imm         = imm_b;
                branch_kind = BR_COND;
            end
            default: ;  // Unsupported opcodes retire as no-ops
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_fetch_ctrl.sv ====
/* Sequencer of the core: Wishbone instruction fetch, PC and instruction
   registers, write-back and the commit port. One instruction in flight. */
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::word_t    wb_dat,
    input  logic             wb_ack,
    input  logic             wb_err,
    input  logic             rd_write,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    alu_result,
    input  logic             jump_en,
    input  rv_pkg::word_t    jump_target,
    output logic             wb_cyc,
    output logic             wb_stb,
    output rv_pkg::word_t    wb_adr,
    output rv_pkg::word_t    instr,
    output rv_pkg::word_t    pc,
    output logic             rf_we,
    output rv_pkg::reg_idx_t rf_waddr,
    output rv_pkg::word_t    rf_wdata,
    output logic             commit_valid,
    output rv_pkg::word_t    commit_pc,
    output rv_pkg::reg_idx_t commit_rd,
    output logic             commit_we,
    output rv_pkg::word_t    commit_wdata,
    output logic             fetch_error
);
    import rv_pkg::*;

    typedef enum logic [1:0] {FETCH, EXECUTE, HALT} state_t;

    state_t state;
    logic   cyc_q;
    logic   fetch_done;

    assign fetch_done = state == FETCH && cyc_q && wb_ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            cyc_q <= 1'b0;
            pc    <= RESET_PC;
        end else begin
            unique case (state)
                FETCH: begin
                    if (fetch_done) begin
                        state <= EXECUTE;
                        cyc_q <= 1'b0;   // Cycle ends after the ack
                    end else if (cyc_q && wb_err) begin
                        state <= HALT;
                        cyc_q <= 1'b0;
                    end else begin
                        cyc_q <= 1'b1;   // First request after reset
                    end
                end
                EXECUTE: begin
                    state <= FETCH;
                    cyc_q <= 1'b1;
                    pc    <= jump_en ? jump_target : pc + 32'd4;
                end
                default: cyc_q <= 1'b0;  // Stuck until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= wb_dat;
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q && state == FETCH;
    assign wb_adr = pc;  // Held by the PC register through wait states

    assign commit_valid = state == EXECUTE;
    assign rf_we        = commit_valid && rd_write;
    assign rf_waddr     = rd;
    assign rf_wdata     = alu_result;

    // Non-writing instructions report rd and data as zero
    assign commit_pc    = pc;
    assign commit_we    = rf_we;
    assign commit_rd    = rd_write ? rd : '0;
    assign commit_wdata = rd_write ? alu_result : '0;
    assign fetch_error  = state == HALT;

    // Request stays inside the cycle with a stable address until answered
    stb_held_until_answer: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack && !wb_err |=> wb_stb && wb_cyc && $stable(wb_adr));

    // Bus must be idle while an instruction retires
    no_commit_during_fetch: assert property (@(posedge clk) disable iff (reset)
        !(commit_valid && wb_cyc));

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
/* Widths, reset PC, opcodes and control encodings shared by the RV32I core.
   Core modules import it inside their bodies. */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;   // Data or address word
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC = 32'h8000_0000;

    // Major opcodes kept by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_t;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_t;

    typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} branch_kind_t;

endpackage

`default_nettype wire

// ==== rv_regfile.sv ====
/* Integer register file, 32 words with two combinational read ports and
   one write port taken at the clock edge. */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             rf_we,
    input  rv_pkg::reg_idx_t rf_waddr,
    input  rv_pkg::word_t    rf_wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin  // x0 stays hardwired
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // Entry 0 must hold zero across every write since reset
    x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0));

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
/* Testbench for the RV32I core: program and expected-commit tables, a Wishbone
   slave memory with random wait states, error injection and a watchdog. */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int PROG_WORDS      = 28;
    localparam int NUM_COMMITS     = 24;
    localparam int WATCHDOG_CYCLES = NUM_COMMITS * 6 + 100;

    logic     clk;
    logic     reset;
    word_t    wb_dat;
    logic     wb_ack;
    logic     wb_err;
    logic     wb_cyc;
    logic     wb_stb;
    word_t    wb_adr;
    logic     commit_valid;
    word_t    commit_pc;
    reg_idx_t commit_rd;
    logic     commit_we;
    word_t    commit_wdata;
    logic     fetch_error;
    logic     end_of_test;

    word_t    prog [PROG_WORDS];
    word_t    exp_pc [NUM_COMMITS];
    reg_idx_t exp_rd [NUM_COMMITS];
    logic     exp_we [NUM_COMMITS];
    word_t    exp_wdata [NUM_COMMITS];
    int       exp_count;
    int       bus_errors;
    int       chk_commits;
    int       chk_errors;

    rv_core DUT (
        .clk          (clk),
        .reset        (reset),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_wdata (commit_wdata),
        .fetch_error  (fetch_error)
    );

    rv_checker #(.NUM_COMMITS(NUM_COMMITS)) u_checker (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_wdata (commit_wdata),
        .fetch_error  (fetch_error),
        .end_of_test  (end_of_test),
        .exp_pc       (exp_pc),
        .exp_rd       (exp_rd),
        .exp_we       (exp_we),
        .exp_wdata    (exp_wdata),
        .commits      (chk_commits),
        .errors       (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_program();
        prog[0]  = 32'hFFB0_0093;  // addi x1, x0, -5
        prog[1]  = 32'h0030_0113;  // addi x2, x0, 3
        prog[2]  = 32'h0020_81B3;  // add  x3, x1, x2
        prog[3]  = 32'h4011_0233;  // sub  x4, x2, x1
        prog[4]  = 32'h0021_12B3;  // sll  x5, x2, x2
        prog[5]  = 32'h0020_A333;  // slt  x6, x1, x2
        prog[6]  = 32'h0020_B3B3;  // sltu x7, x1, x2
        prog[7]  = 32'h0020_D433;  // srl  x8, x1, x2
        prog[8]  = 32'h4020_D4B3;  // sra  x9, x1, x2
        prog[9]  = 32'h0020_C533;  // xor  x10, x1, x2
        prog[10] = 32'h0022_65B3;  // or   x11, x4, x2
        prog[11] = 32'h0040_F633;  // and  x12, x1, x4
        prog[12] = 32'h0071_0013;  // addi x0, x2, 7
        prog[13] = 32'h0020_06B3;  // add  x13, x0, x2
        prog[14] = 32'h1234_5737;  // lui  x14, 0x12345
        prog[15] = 32'h0000_1797;  // auipc x15, 0x1
        prog[16] = 32'h00D1_0463;  // beq  x2, x13, +8 (taken)
        prog[17] = 32'h0010_0813;  // addi x16, x0, 1 (skipped)
        prog[18] = 32'h0011_4463;  // blt  x2, x1, +8 (not taken)
        prog[19] = 32'h0011_6463;  // bltu x2, x1, +8 (taken)
        prog[20] = 32'h0020_0813;  // addi x16, x0, 2 (skipped)
        prog[21] = 32'h0080_08EF;  // jal  x17, +8
        prog[22] = 32'h0030_0813;  // addi x16, x0, 3 (skipped)
        prog[23] = 32'h00D8_8967;  // jalr x18, 13(x17), lands on 0x64
        prog[24] = 32'h0040_0813;  // addi x16, x0, 4 (skipped)
        prog[25] = 32'hFFC0_A993;  // slti  x19, x1, -4
        prog[26] = 32'h4010_DA13;  // srai  x20, x1, 1
        prog[27] = 32'hFFF1_3A93;  // sltiu x21, x2, -1
    endtask

    task automatic expect_commit(input logic [7:0] pc_off, input reg_idx_t rd,
                                 input logic we, input word_t wdata);
        exp_pc[exp_count]    = RESET_PC + 32'(pc_off);
        exp_rd[exp_count]    = rd;
        exp_we[exp_count]    = we;
        exp_wdata[exp_count] = wdata;
        exp_count++;
    endtask

    // Execution order, branches skip the filler words
    task automatic load_expected();
        exp_count = 0;
        expect_commit(8'h00, 5'd1, 1'b1, 32'hFFFF_FFFB);
        expect_commit(8'h04, 5'd2, 1'b1, 32'h0000_0003);
        expect_commit(8'h08, 5'd3, 1'b1, 32'hFFFF_FFFE);
        expect_commit(8'h0C, 5'd4, 1'b1, 32'h0000_0008);
        expect_commit(8'h10, 5'd5, 1'b1, 32'h0000_0018);
        expect_commit(8'h14, 5'd6, 1'b1, 32'h0000_0001);
        expect_commit(8'h18, 5'd7, 1'b1, 32'h0000_0000);
        expect_commit(8'h1C, 5'd8, 1'b1, 32'h1FFF_FFFF);
        expect_commit(8'h20, 5'd9, 1'b1, 32'hFFFF_FFFF);
        expect_commit(8'h24, 5'd10, 1'b1, 32'hFFFF_FFF8);
        expect_commit(8'h28, 5'd11, 1'b1, 32'h0000_000B);
        expect_commit(8'h2C, 5'd12, 1'b1, 32'h0000_0008);
        expect_commit(8'h30, 5'd0, 1'b1, 32'h0000_000A);  // x0 write still commits
        expect_commit(8'h34, 5'd13, 1'b1, 32'h0000_0003);
        expect_commit(8'h38, 5'd14, 1'b1, 32'h1234_5000);
        expect_commit(8'h3C, 5'd15, 1'b1, 32'h8000_103C);
        expect_commit(8'h40, 5'd0, 1'b0, 32'h0000_0000);
        expect_commit(8'h48, 5'd0, 1'b0, 32'h0000_0000);
        expect_commit(8'h4C, 5'd0, 1'b0, 32'h0000_0000);
        expect_commit(8'h54, 5'd17, 1'b1, 32'h8000_0058);
        expect_commit(8'h5C, 5'd18, 1'b1, 32'h8000_0060);
        expect_commit(8'h64, 5'd19, 1'b1, 32'h0000_0001);
        expect_commit(8'h68, 5'd20, 1'b1, 32'hFFFF_FFFD);
        expect_commit(8'h6C, 5'd21, 1'b1, 32'h0000_0001);
    endtask

    // One Wishbone read, answered with ack and data or with err
    task automatic serve_fetch(input logic inject_err);
        int    waits;
        int    idx;
        word_t offset;
        waits = $urandom % 4;
        do @(posedge clk); while (!(wb_cyc && wb_stb));
        repeat (waits) @(posedge clk);
        offset = wb_adr - RESET_PC;
        idx    = int'(offset >> 2);
        if (inject_err) begin
            wb_err <= 1'b1;
        end else if (offset < PROG_WORDS * 4) begin
            wb_dat <= prog[idx];
            wb_ack <= 1'b1;
        end else begin
            $display("Memory model: fetch outside the program at %0d ns, address %h",
                     $time, wb_adr);
            bus_errors++;
            wb_dat <= 32'h0000_0013;  // nop
            wb_ack <= 1'b1;
        end
        @(posedge clk);
        wb_ack <= 1'b0;
        wb_err <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h9bee));
        reset       <= 1'b1;
        wb_dat      <= '0;
        wb_ack      <= 1'b0;
        wb_err      <= 1'b0;
        end_of_test <= 1'b0;
        bus_errors  = 0;
        load_program();
        load_expected();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_COMMITS; i++) begin
            serve_fetch(1'b0);
        end
        serve_fetch(1'b1);  // Bus error on the next fetch
        repeat (10) @(posedge clk);
        end_of_test <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Commits %0d of %0d, checker errors %0d, memory model errors %0d",
                 chk_commits, NUM_COMMITS, chk_errors, bus_errors);
        if (chk_errors == 0 && bus_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the core stopped making progress",
                 WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
